/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert
TOP       := rv_fe_tb
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* compile.f */
+incdir+hdl
hdl/rv_fe_pkg.sv
hdl/pc_fetch.sv
hdl/pipe_ctrl.sv
hdl/if_id.sv
hdl/id_decode.sv
hdl/rv_fe_top.sv
verification/rv_fe_props.sv
verification/rv_fe_tb.sv

/* hdl/id_decode.sv */
`timescale 1ns/10ps
`include "rv_fe_settings.svh"

module id_decode (
    input  rv_fe_pkg::fetch_s   id_in,
    output rv_fe_pkg::decoded_s dec
);

    rv_fe_pkg::inst_u inst;
    logic             nonzero;
    logic [11:0]      imm_i;
    logic [11:0]      imm_s;
    logic [12:0]      imm_b;
    logic [31:0]      imm_u;
    logic [20:0]      imm_j;

    assign inst    = id_in.inst;
    assign nonzero = (inst.raw != `RV_FE_BUBBLE);

    // immediates reassembled from the per-format views
    assign imm_i = inst.i_fmt.imm_11_0;
    assign imm_s = {inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
    assign imm_b = {inst.b_fmt.imm_12, inst.b_fmt.imm_11,
                    inst.b_fmt.imm_10_5, inst.b_fmt.imm_4_1, 1'b0};
    assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
    assign imm_j = {inst.j_fmt.imm_20, inst.j_fmt.imm_19_12,
                    inst.j_fmt.imm_11, inst.j_fmt.imm_10_1, 1'b0};

    always_comb begin
        dec        = '0;  // absent fields read as zero
        dec.valid  = nonzero;
        dec.pc     = id_in.pc;
        dec.opcode = inst.r_fmt.opcode;
        dec.fmt    = rv_fe_pkg::fmt_bad;
        case (inst.r_fmt.opcode)
            `RV_FE_OP_OP,
            `RV_FE_OP_OP32: begin
                dec.fmt = rv_fe_pkg::fmt_r;
                dec.rd  = inst.r_fmt.rd;
                dec.rs1 = inst.r_fmt.rs1;
                dec.rs2 = inst.r_fmt.rs2;
            end
            `RV_FE_OP_LOAD,
            `RV_FE_OP_OP_IMM,
            `RV_FE_OP_OP_IMM32,
            `RV_FE_OP_JALR,
            `RV_FE_OP_MISC_MEM,
            `RV_FE_OP_SYSTEM: begin
                dec.fmt = rv_fe_pkg::fmt_i;
                dec.rd  = inst.i_fmt.rd;
                dec.rs1 = inst.i_fmt.rs1;
                dec.imm = {{(`RV_FE_XLEN-12){imm_i[11]}}, imm_i};
            end
            `RV_FE_OP_STORE: begin
                dec.fmt = rv_fe_pkg::fmt_s;
                dec.rs1 = inst.s_fmt.rs1;
                dec.rs2 = inst.s_fmt.rs2;
                dec.imm = {{(`RV_FE_XLEN-12){imm_s[11]}}, imm_s};
            end
            `RV_FE_OP_BRANCH: begin
                dec.fmt = rv_fe_pkg::fmt_b;
                dec.rs1 = inst.b_fmt.rs1;
                dec.rs2 = inst.b_fmt.rs2;
                dec.imm = {{(`RV_FE_XLEN-13){imm_b[12]}}, imm_b};
            end
            `RV_FE_OP_LUI,
            `RV_FE_OP_AUIPC: begin
                dec.fmt = rv_fe_pkg::fmt_u;
                dec.rd  = inst.u_fmt.rd;
                dec.imm = {{(`RV_FE_XLEN-32){imm_u[31]}}, imm_u};  // upper 20 bits
            end
            `RV_FE_OP_JAL: begin
                dec.fmt = rv_fe_pkg::fmt_j;
                dec.rd  = inst.j_fmt.rd;
                dec.imm = {{(`RV_FE_XLEN-21){imm_j[20]}}, imm_j};
            end
            default: begin
                // bubble lands here too, but stays not valid
                dec.illegal = nonzero;
            end
        endcase
    end

endmodule

/* hdl/if_id.sv */
`timescale 1ns/10ps
`include "rv_fe_settings.svh"

module if_id (
    input  logic              clk,
    input  logic              rst_n,
    input  rv_fe_pkg::stall_s stall,
    input  logic              flush,
    input  rv_fe_pkg::fetch_s fe_in,
    output rv_fe_pkg::fetch_s id_out,
    output logic              take
);

    logic pend_flush;  // flush seen while execute was stalled
    logic kill;
    logic to_bubble;

    assign kill = flush | pend_flush;

    // flush first, then IF stalled with ID running
    assign to_bubble = kill | (stall.fe & ~stall.id);

    // fe clear means the fetch buffer holds a word and nothing is frozen
    assign take = ~kill & ~stall.fe;

    always_ff @(posedge clk) begin
        if (!rst_n || to_bubble) begin
            id_out.pc       <= '0;
            id_out.inst.raw <= `RV_FE_BUBBLE;
        end else if (!stall.id) begin
            id_out <= fe_in;
        end
        // hold for execute while stall.id is set
    end

    // remembered until the full stall is released,
    // then the register is bubbled once more at that edge
    always_ff @(posedge clk) begin
        if (!rst_n)
            pend_flush <= 1'b0;
        else if (flush && stall.ex)
            pend_flush <= 1'b1;
        else if (!stall.ex)
            pend_flush <= 1'b0;
    end

endmodule

/* hdl/pc_fetch.sv */
`timescale 1ns/10ps
`include "rv_fe_settings.svh"

module pc_fetch (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv_fe_pkg::stall_s      stall,
    input  logic                   redirect_valid,
    input  logic [`RV_FE_XLEN-1:0] redirect_pc,
    input  logic                   inst_valid,
    input  logic [`RV_FE_ILEN-1:0] inst_data,
    input  logic                   take,
    output logic                   inst_req,
    output logic [`RV_FE_XLEN-1:0] inst_addr,
    output logic                   fetch_wait,
    output rv_fe_pkg::fetch_s      fe_out
);

    logic [`RV_FE_XLEN-1:0] pc_q;        // address of the current or next request
    logic                   req_q;       // request outstanding
    logic                   stale_q;     // outstanding request was cancelled
    logic                   buf_valid_q;
    rv_fe_pkg::fetch_s      buf_q;
    logic                   ret;
    logic                   keep_ret;
    logic                   issue;

    assign ret      = req_q & inst_valid;
    assign keep_ret = ret & ~stale_q & ~redirect_valid;  // stale or cancelled returns drop here

    // new request once nothing is in flight and the buffer frees up
    assign issue = ~req_q & (~buf_valid_q | take | redirect_valid);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= `RV_FE_RESET_PC;
        end else if (redirect_valid) begin
            pc_q <= redirect_pc;
        end else if (take && !stall.pc) begin
            pc_q <= pc_q + `RV_FE_XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= 1'b0;
        end else if (req_q) begin
            if (inst_valid)
                req_q <= 1'b0;
        end else if (issue) begin
            req_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            stale_q <= 1'b0;
        else if (redirect_valid)
            stale_q <= req_q & ~inst_valid;  // its return is still to come
        else if (ret)
            stale_q <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            buf_valid_q <= 1'b0;
        else if (redirect_valid)
            buf_valid_q <= 1'b0;
        else if (keep_ret)
            buf_valid_q <= 1'b1;
        else if (take)
            buf_valid_q <= 1'b0;
    end

    // returned word with the address it came from
    always_ff @(posedge clk) begin
        if (keep_ret) begin
            buf_q.pc       <= pc_q;
            buf_q.inst.raw <= inst_data;
        end
    end

    assign inst_req   = req_q;
    assign inst_addr  = pc_q;
    assign fetch_wait = ~buf_valid_q;
    assign fe_out     = buf_q;

endmodule

/* hdl/pipe_ctrl.sv */
`timescale 1ns/10ps

module pipe_ctrl (
    input  logic              fetch_wait,
    input  logic              ex_stall,
    output rv_fe_pkg::stall_s stall
);

    // central stall policy for the front end
    //
    // an execute stall freezes every stage, so IF/ID keeps its word
    // and the decoded output stays put until execute takes it.
    // a fetch wait only stops the PC and fetch side; ID and EX keep
    // running and IF/ID fills with bubbles meanwhile.

    always_comb begin
        stall = '0;
        if (ex_stall) begin
            stall.pc = 1'b1;
            stall.fe = 1'b1;
            stall.id = 1'b1;
            stall.ex = 1'b1;
        end else if (fetch_wait) begin
            stall.pc = 1'b1;  // nothing to hand on yet
            stall.fe = 1'b1;
        end
    end

endmodule

/* hdl/rv_fe_pkg.sv */
`include "rv_fe_settings.svh"

package rv_fe_pkg;

    // per-format views of one instruction word, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_s;

    typedef struct packed {
        logic [11:0] imm_11_0;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_s;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_fmt_s;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_s;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_s;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_s;

    typedef union packed {
        logic [`RV_FE_ILEN-1:0] raw;
        r_fmt_s                 r_fmt;
        i_fmt_s                 i_fmt;
        s_fmt_s                 s_fmt;
        b_fmt_s                 b_fmt;
        u_fmt_s                 u_fmt;
        j_fmt_s                 j_fmt;
    } inst_u;

    typedef struct packed {
        logic [`RV_FE_XLEN-1:0] pc;
        inst_u                  inst;
    } fetch_s;

    typedef enum logic [2:0] {
        fmt_r,
        fmt_i,
        fmt_s,
        fmt_b,
        fmt_u,
        fmt_j,
        fmt_bad
    } fmt_e;

    typedef struct packed {
        logic                   valid;
        logic                   illegal;
        fmt_e                   fmt;
        logic [`RV_FE_XLEN-1:0] pc;
        logic [4:0]             rd;
        logic [4:0]             rs1;
        logic [4:0]             rs2;
        logic [`RV_FE_XLEN-1:0] imm;     // sign-extended
        logic [6:0]             opcode;
    } decoded_s;

    typedef struct packed {
        logic pc;
        logic fe;
        logic id;
        logic ex;
    } stall_s;

endpackage

/* hdl/rv_fe_settings.svh */
`ifndef RV_FE_SETTINGS_SVH
`define RV_FE_SETTINGS_SVH

// datapath widths
`define RV_FE_XLEN      64
`define RV_FE_ILEN      32

// first fetch address after reset
`define RV_FE_RESET_PC  64'h8000_0000

// all-zero word marks a bubble in IF/ID
`define RV_FE_BUBBLE    32'h0000_0000

// rv64i major opcodes
`define RV_FE_OP_LUI      7'b0110111
`define RV_FE_OP_AUIPC    7'b0010111
`define RV_FE_OP_JAL      7'b1101111
`define RV_FE_OP_JALR     7'b1100111
`define RV_FE_OP_BRANCH   7'b1100011
`define RV_FE_OP_LOAD     7'b0000011
`define RV_FE_OP_STORE    7'b0100011
`define RV_FE_OP_OP_IMM   7'b0010011
`define RV_FE_OP_OP_IMM32 7'b0011011
`define RV_FE_OP_OP       7'b0110011
`define RV_FE_OP_OP32     7'b0111011
`define RV_FE_OP_MISC_MEM 7'b0001111
`define RV_FE_OP_SYSTEM   7'b1110011

`endif

/* hdl/rv_fe_top.sv */
`timescale 1ns/10ps
`include "rv_fe_settings.svh"

module rv_fe_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   inst_valid,
    input  logic [`RV_FE_ILEN-1:0] inst_data,
    input  logic                   redirect_valid,
    input  logic [`RV_FE_XLEN-1:0] redirect_pc,
    input  logic                   ex_stall,
    output logic                   inst_req,
    output logic [`RV_FE_XLEN-1:0] inst_addr,
    output rv_fe_pkg::decoded_s    dec
);

    rv_fe_pkg::fetch_s fe_buf;   // fetch buffer contents
    rv_fe_pkg::fetch_s id_q;     // IF/ID register
    rv_fe_pkg::stall_s stall;
    logic              fetch_wait;
    logic              take;

    pc_fetch i_pc_fetch (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall          (stall),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .take           (take),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .fetch_wait     (fetch_wait),
        .fe_out         (fe_buf)
    );

    pipe_ctrl i_pipe_ctrl (
        .fetch_wait (fetch_wait),
        .ex_stall   (ex_stall),
        .stall      (stall)
    );

    // taken branch from execute flushes IF/ID
    if_id i_if_id (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .flush  (redirect_valid),
        .fe_in  (fe_buf),
        .id_out (id_q),
        .take   (take)
    );

    id_decode i_id_decode (
        .id_in (id_q),
        .dec   (dec)
    );

endmodule

/* verification/rv_fe_props.sv */
`timescale 1ns/10ps

module rv_fe_props (
    input logic                clk,
    input logic                rst_n,
    input logic                inst_valid,
    input logic                redirect_valid,
    input logic                ex_stall,
    input logic                inst_req,
    input logic [63:0]         inst_addr,
    input rv_fe_pkg::decoded_s dec
);

    // word aligned fetch address
    a_addr_aligned: assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_req |-> inst_addr[1:0] == 2'b00
    ) else $error("fetch address not 4-byte aligned");

    // request held until its return, unless a redirect moves the PC
    a_req_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        inst_req && !inst_valid && !redirect_valid |=> inst_req && $stable(inst_addr)
    ) else $error("pending request dropped or changed address");

    a_dec_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        ex_stall && !redirect_valid |=> $stable(dec)
    ) else $error("decoded output moved during execute stall");

    a_no_req_in_reset: assert property (
        @(posedge clk)
        !rst_n |=> !inst_req
    ) else $error("request raised during reset");

endmodule

bind rv_fe_top rv_fe_props i_props (.*);

/* verification/rv_fe_tb.sv */
`timescale 1ns/10ps
`include "rv_fe_settings.svh"

module rv_fe_tb;

    localparam int num_insts    = 600;
    localparam int reset_cycles = 16;
    localparam int max_cycles   = num_insts * 12 + reset_cycles;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   inst_valid;
    logic [`RV_FE_ILEN-1:0] inst_data;
    logic                   redirect_valid;
    logic [`RV_FE_XLEN-1:0] redirect_pc;
    logic                   ex_stall;
    logic                   inst_req;
    logic [`RV_FE_XLEN-1:0] inst_addr;
    rv_fe_pkg::decoded_s    dec;

    logic [31:0] mem [logic [63:0]];  // program image, filled on demand

    logic                   mem_busy;
    logic [`RV_FE_XLEN-1:0] mem_addr;
    int                     mem_lat;
    logic                   seen_return;
    logic                   first_req_done;

    logic [`RV_FE_XLEN-1:0] exp_pc;
    rv_fe_pkg::decoded_s    exp_dec;
    rv_fe_pkg::decoded_s    prev_dec;
    logic                   prev_hold;
    int                     consumed;
    int                     since_redirect;
    int                     redirect_gap;
    int                     cycles;

    rv_fe_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst_valid     (inst_valid),
        .inst_data      (inst_data),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .ex_stall       (ex_stall),
        .inst_req       (inst_req),
        .inst_addr      (inst_addr),
        .dec            (dec)
    );

    always #20 clk = ~clk;

    function automatic logic [6:0] legal_opcode(int unsigned idx);
        case (idx)
            0:       return `RV_FE_OP_LUI;
            1:       return `RV_FE_OP_AUIPC;
            2:       return `RV_FE_OP_JAL;
            3:       return `RV_FE_OP_JALR;
            4:       return `RV_FE_OP_BRANCH;
            5:       return `RV_FE_OP_LOAD;
            6:       return `RV_FE_OP_STORE;
            7:       return `RV_FE_OP_OP_IMM;
            8:       return `RV_FE_OP_OP_IMM32;
            9:       return `RV_FE_OP_OP;
            10:      return `RV_FE_OP_OP32;
            11:      return `RV_FE_OP_MISC_MEM;
            default: return `RV_FE_OP_SYSTEM;
        endcase
    endfunction

    function automatic bit is_legal(logic [6:0] op);
        for (int i = 0; i < 13; i++) begin
            if (legal_opcode(i) == op)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // mostly legal opcodes, about one in sixteen illegal, never zero
    function automatic logic [31:0] random_word();
        logic [31:0] w;
        logic [6:0]  op;
        w = '0;
        while (w == '0) begin
            if ($urandom % 16 == 0) begin
                op = 7'($urandom);
                while (is_legal(op))
                    op = 7'($urandom);
            end else begin
                op = legal_opcode($urandom % 13);
            end
            w = {25'($urandom), op};
        end
        return w;
    endfunction

    // reference decode straight from the ISA bit positions
    function automatic rv_fe_pkg::decoded_s expected_decode(logic [63:0] pc, logic [31:0] w);
        rv_fe_pkg::inst_u    u;
        rv_fe_pkg::decoded_s e;
        u.raw    = w;
        e        = '0;
        e.valid  = 1'b1;
        e.pc     = pc;
        e.opcode = w[6:0];
        e.fmt    = rv_fe_pkg::fmt_bad;
        case (w[6:0])
            `RV_FE_OP_OP, `RV_FE_OP_OP32: begin
                e.fmt = rv_fe_pkg::fmt_r;
                e.rd  = u.r_fmt.rd;
                e.rs1 = u.r_fmt.rs1;
                e.rs2 = u.r_fmt.rs2;
            end
            `RV_FE_OP_LOAD, `RV_FE_OP_OP_IMM, `RV_FE_OP_OP_IMM32,
            `RV_FE_OP_JALR, `RV_FE_OP_MISC_MEM, `RV_FE_OP_SYSTEM: begin
                e.fmt = rv_fe_pkg::fmt_i;
                e.rd  = u.i_fmt.rd;
                e.rs1 = u.i_fmt.rs1;
                e.imm = {{52{w[31]}}, w[31:20]};
            end
            `RV_FE_OP_STORE: begin
                e.fmt = rv_fe_pkg::fmt_s;
                e.rs1 = u.s_fmt.rs1;
                e.rs2 = u.s_fmt.rs2;
                e.imm = {{52{w[31]}}, w[31:25], w[11:7]};
            end
            `RV_FE_OP_BRANCH: begin
                e.fmt = rv_fe_pkg::fmt_b;
                e.rs1 = u.b_fmt.rs1;
                e.rs2 = u.b_fmt.rs2;
                e.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            `RV_FE_OP_LUI, `RV_FE_OP_AUIPC: begin
                e.fmt = rv_fe_pkg::fmt_u;
                e.rd  = u.u_fmt.rd;
                e.imm = {{32{w[31]}}, w[31:12], 12'b0};
            end
            `RV_FE_OP_JAL: begin
                e.fmt = rv_fe_pkg::fmt_j;
                e.rd  = u.j_fmt.rd;
                e.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            default: begin
                e.illegal = 1'b1;
            end
        endcase
        return e;
    endfunction

    task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
        assert (got === exp) else begin
            $display("error: %s got %h expected %h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    task automatic require_true(bit cond, string what);
        assert (cond) else begin
            $display("%s", what);
            $display("Result: FAILED");
            $fatal(1);
        end
    endtask

    // memory answers each request after 1 to 4 cycles
    task automatic memory_step();
        if (inst_valid) begin
            inst_valid = 1'b0;
            mem_busy   = 1'b0;
        end
        if (!mem_busy && inst_req) begin
            if (!first_req_done) begin
                check_value("inst_addr", inst_addr, `RV_FE_RESET_PC);
                first_req_done = 1'b1;
            end
            mem_busy = 1'b1;
            mem_addr = inst_addr;
            mem_lat  = 1 + int'($urandom % 4);
            if (!mem.exists(mem_addr))
                mem[mem_addr] = random_word();
        end
        if (mem_busy && !inst_valid) begin
            mem_lat--;
            if (mem_lat == 0) begin
                inst_valid  = 1'b1;
                inst_data   = mem[mem_addr];
                seen_return = 1'b1;
            end
        end
    endtask

    // random stall and redirects, then check what execute takes
    task automatic execute_step();
        if (prev_hold) begin
            assert (dec === prev_dec) else begin
                $display("error: dec got %h expected %h", dec, prev_dec);
                $display("Result: FAILED");
                $fatal(1);
            end
        end
        require_true(!dec.valid || seen_return, "decoded output valid before any fetch returned");

        ex_stall       = ($urandom % 5 == 0);
        redirect_valid = 1'b0;
        if (since_redirect >= redirect_gap) begin
            redirect_valid = 1'b1;
            redirect_pc    = {32'h0, $urandom & 32'hffff_fffc};
            since_redirect = 0;
            redirect_gap   = 20 + int'($urandom % 21);
        end

        if (dec.valid && !ex_stall && !redirect_valid) begin
            check_value("dec.pc", dec.pc, exp_pc);
            require_true(mem.exists(exp_pc), "consumed instruction was never fetched");
            exp_dec = expected_decode(exp_pc, mem[exp_pc]);
            check_value("dec.fmt", 64'(dec.fmt), 64'(exp_dec.fmt));
            check_value("dec.illegal", 64'(dec.illegal), 64'(exp_dec.illegal));
            check_value("dec.opcode", 64'(dec.opcode), 64'(exp_dec.opcode));
            check_value("dec.rd", 64'(dec.rd), 64'(exp_dec.rd));
            check_value("dec.rs1", 64'(dec.rs1), 64'(exp_dec.rs1));
            check_value("dec.rs2", 64'(dec.rs2), 64'(exp_dec.rs2));
            check_value("dec.imm", dec.imm, exp_dec.imm);
            exp_pc = exp_pc + 64'd4;
            consumed++;
            since_redirect++;
        end
        if (redirect_valid)
            exp_pc = redirect_pc;  // next taken word starts here

        prev_dec  = dec;
        prev_hold = ex_stall && !redirect_valid;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > max_cycles) begin
            $display("timeout, only %0d instructions consumed", consumed);
            $display("Result: FAILED");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(32'hfc98));
        rst_n          = 1'b0;
        inst_valid     = 1'b0;
        inst_data      = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        ex_stall       = 1'b0;
        mem_busy       = 1'b0;
        mem_addr       = '0;
        mem_lat        = 0;
        seen_return    = 1'b0;
        first_req_done = 1'b0;
        exp_pc         = `RV_FE_RESET_PC;
        prev_dec       = '0;
        prev_hold      = 1'b0;
        consumed       = 0;
        since_redirect = 0;
        redirect_gap   = 30;

        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;

        while (consumed < num_insts) begin
            @(negedge clk);
            memory_step();
            execute_step();
        end
        $display("Result: PASSED");
        $finish;
    end

endmodule
